/* flist.f */
source/core_pkg.sv
source/isa_pkg.sv
source/issue_ctrl.sv
source/tag_regfile.sv
source/alu_station.sv
source/mul_station.sv
source/cdb_arbiter.sv
source/debug_mux.sv
source/tomasulo_core.sv
test/tb_tomasulo_core.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and decide by the testbench's closing message
verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module tb_tomasulo_core \
	-Mdir obj_dir &&
./obj_dir/Vtb_tomasulo_core | tee /dev/stderr | grep -q "Simulation finished: PASS" &&
echo "run.sh: simulation passed" || { echo "run.sh: simulation failed"; exit 1; }

/* source/alu_station.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_station (
	input logic dbg_if,
	input logic rst,
	input core_pkg::issue_t issue_i,
	input core_pkg::cdb_t cdb_i,
	input logic grant_i,
	output logic busy_o,
	output logic [core_pkg::TAG_W-1:0] free_tag_o,
	output logic req_o,
	output core_pkg::cdb_t result_o
);

	typedef logic [$clog2(core_pkg::ALU_RS)-1:0] idx_t;
	typedef logic [core_pkg::TAG_W-1:0] tag_t;

	typedef struct packed {
		logic busy;
		core_pkg::alu_op_e op;
		core_pkg::tagged_t a;
		core_pkg::tagged_t b;
	} entry_t;

	entry_t [core_pkg::ALU_RS-1:0] rs_q;
	idx_t free_idx, sel_idx;
	logic sel_vld;

	function automatic logic [core_pkg::XLEN-1:0] alu_calc(core_pkg::alu_op_e op,
		logic [core_pkg::XLEN-1:0] a, logic [core_pkg::XLEN-1:0] b);
		case (op)
			core_pkg::ALU_SUB: return a - b;
			core_pkg::ALU_AND: return a & b;
			core_pkg::ALU_OR: return a | b;
			core_pkg::ALU_XOR: return a ^ b;
			core_pkg::ALU_SLL: return a << b[4:0];	// Shift amount from low five bits
			core_pkg::ALU_SRL: return a >> b[4:0];
			default: return a + b;
		endcase
	endfunction

	//--------------------------------------------------
	// Free and ready pickers, lowest index first
	//--------------------------------------------------
	always_comb begin
		busy_o = 1'b1;
		free_idx = '0;
		sel_vld = 1'b0;
		sel_idx = '0;
		for (int i = core_pkg::ALU_RS - 1; i >= 0; i--) begin
			if (!rs_q[i].busy) begin
				busy_o = 1'b0;
				free_idx = idx_t'(i);
			end
			if (rs_q[i].busy && rs_q[i].a.tag == '0 && rs_q[i].b.tag == '0) begin
				sel_vld = 1'b1;
				sel_idx = idx_t'(i);
			end
		end
	end

	assign free_tag_o = core_pkg::ALU_TAG_BASE + tag_t'(free_idx);

	// Single-cycle execute straight onto the request
	assign req_o = sel_vld;
	assign result_o.valid = sel_vld;
	assign result_o.tag = core_pkg::ALU_TAG_BASE + tag_t'(sel_idx);
	assign result_o.data = alu_calc(rs_q[sel_idx].op, rs_q[sel_idx].a.val, rs_q[sel_idx].b.val);

	always_ff @(posedge dbg_if) begin
		if (rst) begin
			for (int i = 0; i < core_pkg::ALU_RS; i++) begin
				rs_q[i].busy <= 1'b0;
			end
		end else begin
			for (int i = 0; i < core_pkg::ALU_RS; i++) begin
				if (issue_i.alu_issue && free_idx == idx_t'(i)) begin
					rs_q[i].busy <= 1'b1;
					rs_q[i].op <= issue_i.alu_op;
					rs_q[i].a <= issue_i.op_a;	// Already bypassed by the register file
					rs_q[i].b <= issue_i.op_b;
				end else begin
					if (grant_i && sel_vld && sel_idx == idx_t'(i)) begin
						rs_q[i].busy <= 1'b0;	// Retire on broadcast
					end
					rs_q[i].a <= core_pkg::snoop(rs_q[i].a, cdb_i);
					rs_q[i].b <= core_pkg::snoop(rs_q[i].b, cdb_i);
				end
			end
		end
	end

endmodule

`default_nettype wire

/* source/cdb_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module cdb_arbiter (
	input logic alu_req_i,
	input logic mul_req_i,
	input core_pkg::cdb_t alu_res_i,
	input core_pkg::cdb_t mul_res_i,
	output logic alu_grant_o,
	output logic mul_grant_o,
	output core_pkg::cdb_t cdb_o
);

	// ALU first, the multiplier holds its output register
	assign alu_grant_o = alu_req_i;
	assign mul_grant_o = mul_req_i & ~alu_req_i;

	always_comb begin
		cdb_o = '0;	// Idle bus, valid low
		if (alu_grant_o) begin
			cdb_o = alu_res_i;
			cdb_o.valid = 1'b1;
		end else if (mul_grant_o) begin
			cdb_o = mul_res_i;
			cdb_o.valid = 1'b1;
		end
	end

	always_comb begin
		if (!$isunknown({alu_grant_o, mul_grant_o})) begin
			a_one_grant: assert (!(alu_grant_o && mul_grant_o));
		end
	end

endmodule

`default_nettype wire

/* source/core_pkg.sv */
`default_nettype none

package core_pkg;

	//--------------------------------------------------
	// Widths and station counts
	//--------------------------------------------------
	localparam int TAG_W = 3;	// Tag 0 = value ready
	localparam int XLEN = 32;
	localparam int ALU_RS = 2;
	localparam int MUL_RS = 2;
	localparam logic [TAG_W-1:0] ALU_TAG_BASE = 3'd1;	// ALU owns tags 1..2
	localparam logic [TAG_W-1:0] MUL_TAG_BASE = 3'd3;	// MUL owns tags 3..4

	localparam int DBG_W = 40;
	localparam logic [DBG_W-1:0] DBG_DEFAULT = 40'h8AA55_AA558;	// Easy to spot on a scope

	// Register or operand, either ready or waiting on a producer
	typedef struct packed {
		logic [TAG_W-1:0] tag;
		logic [XLEN-1:0] val;
	} tagged_t;

	// One result on the common data bus
	typedef struct packed {
		logic valid;
		logic [TAG_W-1:0] tag;
		logic [XLEN-1:0] data;
	} cdb_t;

	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL
	} alu_op_e;

	// Everything the issue stage hands out in one cycle
	typedef struct packed {
		logic alu_issue;
		logic mul_issue;
		alu_op_e alu_op;
		tagged_t op_a;
		tagged_t op_b;
		logic [TAG_W-1:0] tag;	// Producer tag for rd
		logic rename_en;
		logic [4:0] rd;
	} issue_t;

	// Bus snoop; a waiting word takes the broadcast value on a tag match
	function automatic tagged_t snoop(tagged_t t, cdb_t c);
		tagged_t r;
		r = t;
		if (c.valid && t.tag != '0 && t.tag == c.tag) begin
			r.tag = '0;
			r.val = c.data;
		end
		return r;
	endfunction

endpackage

`default_nettype wire

/* source/debug_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module debug_mux (
	input logic [6:0] debug_addr_i,
	input core_pkg::tagged_t dbg_reg_i,
	input core_pkg::cdb_t cdb_i,
	input logic alu_busy_i,
	input logic mul_busy_i,
	input logic stall_i,
	output logic [core_pkg::DBG_W-1:0] debug_data_o
);

	always_comb begin
		if (debug_addr_i[6:5] == 2'b00) begin
			// Register view, tag above value
			debug_data_o = {{(core_pkg::DBG_W - $bits(core_pkg::tagged_t)){1'b0}}, dbg_reg_i};
		end else begin
			case (debug_addr_i)
				7'd32: debug_data_o = {{(core_pkg::DBG_W - $bits(core_pkg::cdb_t)){1'b0}}, cdb_i};
				7'd33: debug_data_o = {{(core_pkg::DBG_W - 3){1'b0}},
					alu_busy_i, mul_busy_i, stall_i};	// Busy bits and stall
				default: debug_data_o = core_pkg::DBG_DEFAULT;
			endcase
		end
	end

endmodule

`default_nettype wire

/* source/isa_pkg.sv */
`default_nettype none

package isa_pkg;

	//--------------------------------------------------
	// Opcodes
	//--------------------------------------------------
	localparam logic [6:0] OP_REG = 7'b0110011;	// R-type incl. MUL
	localparam logic [6:0] OP_IMM = 7'b0010011;	// I-type ALU

	// funct3 per operation, SUB shares ADD
	localparam logic [2:0] FUNCT3_ADD = 3'b000;
	localparam logic [2:0] FUNCT3_SLL = 3'b001;
	localparam logic [2:0] FUNCT3_XOR = 3'b100;
	localparam logic [2:0] FUNCT3_SRL = 3'b101;
	localparam logic [2:0] FUNCT3_OR = 3'b110;
	localparam logic [2:0] FUNCT3_AND = 3'b111;
	localparam logic [2:0] FUNCT3_MUL = 3'b000;

	localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
	localparam logic [6:0] FUNCT7_SUB = 7'b0100000;
	localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;	// M extension

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm12;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} i_fmt_t;

	// Same instruction word, two field layouts
	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
	} inst_u;

endpackage

`default_nettype wire

/* source/issue_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module issue_ctrl (
	input logic dbg_if,
	input logic rst,
	input logic inst_valid_i,
	input isa_pkg::inst_u inst_i,
	output logic [4:0] rs1_idx_o,
	output logic [4:0] rs2_idx_o,
	input core_pkg::tagged_t rs1_i,
	input core_pkg::tagged_t rs2_i,
	input logic alu_busy_i,
	input logic mul_busy_i,
	input logic [core_pkg::TAG_W-1:0] alu_free_tag_i,
	input logic [core_pkg::TAG_W-1:0] mul_free_tag_i,
	output core_pkg::issue_t issue_o,
	output logic stall_o
);

	logic is_alu, is_mul, use_imm, go;
	core_pkg::alu_op_e alu_op;

	assign rs1_idx_o = inst_i.r_fmt.rs1;	// rs1 sits in the same place in both layouts
	assign rs2_idx_o = inst_i.r_fmt.rs2;

	//--------------------------------------------------
	// Decode
	//--------------------------------------------------
	always_comb begin
		is_alu = 1'b0;
		is_mul = 1'b0;
		use_imm = 1'b0;
		alu_op = core_pkg::ALU_ADD;
		case (inst_i.r_fmt.opcode)
			isa_pkg::OP_REG: begin
				if (inst_i.r_fmt.funct7 == isa_pkg::FUNCT7_MULDIV) begin
					is_mul = inst_i.r_fmt.funct3 == isa_pkg::FUNCT3_MUL;	// Only MUL of the M set
				end else if (inst_i.r_fmt.funct7 == isa_pkg::FUNCT7_SUB) begin
					is_alu = inst_i.r_fmt.funct3 == isa_pkg::FUNCT3_ADD;	// SRA dropped
					alu_op = core_pkg::ALU_SUB;
				end else if (inst_i.r_fmt.funct7 == isa_pkg::FUNCT7_BASE) begin
					is_alu = 1'b1;
					case (inst_i.r_fmt.funct3)
						isa_pkg::FUNCT3_ADD: alu_op = core_pkg::ALU_ADD;
						isa_pkg::FUNCT3_SLL: alu_op = core_pkg::ALU_SLL;
						isa_pkg::FUNCT3_XOR: alu_op = core_pkg::ALU_XOR;
						isa_pkg::FUNCT3_SRL: alu_op = core_pkg::ALU_SRL;
						isa_pkg::FUNCT3_OR: alu_op = core_pkg::ALU_OR;
						isa_pkg::FUNCT3_AND: alu_op = core_pkg::ALU_AND;
						default: is_alu = 1'b0;	// SLT family not supported
					endcase
				end
			end
			isa_pkg::OP_IMM: begin
				use_imm = 1'b1;
				is_alu = 1'b1;
				case (inst_i.i_fmt.funct3)
					isa_pkg::FUNCT3_ADD: alu_op = core_pkg::ALU_ADD;
					isa_pkg::FUNCT3_XOR: alu_op = core_pkg::ALU_XOR;
					isa_pkg::FUNCT3_OR: alu_op = core_pkg::ALU_OR;
					isa_pkg::FUNCT3_AND: alu_op = core_pkg::ALU_AND;
					default: is_alu = 1'b0;
				endcase
			end
			default: ;	// Unknown opcode, consumed and dropped
		endcase
	end

	// Structural hazard only, unknown words never stall
	assign stall_o = inst_valid_i & ((is_alu & alu_busy_i) | (is_mul & mul_busy_i));
	assign go = inst_valid_i & ~stall_o;

	//--------------------------------------------------
	// Issue word
	//--------------------------------------------------
	always_comb begin
		issue_o.alu_issue = go & is_alu;
		issue_o.mul_issue = go & is_mul;
		issue_o.alu_op = alu_op;
		issue_o.op_a = rs1_i;
		if (use_imm) begin
			issue_o.op_b.tag = '0;	// Immediate is always ready
			issue_o.op_b.val = {{(core_pkg::XLEN-12){inst_i.i_fmt.imm12[11]}},
				inst_i.i_fmt.imm12};
		end else begin
			issue_o.op_b = rs2_i;
		end
		issue_o.tag = is_mul ? mul_free_tag_i : alu_free_tag_i;
		issue_o.rd = inst_i.r_fmt.rd;
		issue_o.rename_en = go & (is_alu | is_mul) & (inst_i.r_fmt.rd != 5'd0);	// x0 never renamed
	end

	// One unit per instruction
	a_one_unit: assert property (@(posedge dbg_if) disable iff (rst)
		!(issue_o.alu_issue && issue_o.mul_issue));

endmodule

`default_nettype wire

/* source/mul_station.sv */
`timescale 1ns/1ps
`default_nettype none

module mul_station (
	input logic dbg_if,
	input logic rst,
	input core_pkg::issue_t issue_i,
	input core_pkg::cdb_t cdb_i,
	input logic grant_i,
	output logic busy_o,
	output logic [core_pkg::TAG_W-1:0] free_tag_o,
	output logic req_o,
	output core_pkg::cdb_t result_o
);

	typedef logic [$clog2(core_pkg::MUL_RS)-1:0] idx_t;
	typedef logic [core_pkg::TAG_W-1:0] tag_t;

	typedef struct packed {
		logic busy;
		logic sent;	// Already in the pipeline
		core_pkg::tagged_t a;
		core_pkg::tagged_t b;
	} entry_t;

	// Stage 1 partial products
	typedef struct packed {
		logic valid;
		tag_t tag;
		logic [core_pkg::XLEN-1:0] lo;	// a_lo * b_lo
		logic [15:0] mid;	// Cross terms, low half only
	} s1_t;

	entry_t [core_pkg::MUL_RS-1:0] rs_q;
	s1_t s1_q;
	core_pkg::cdb_t s2_q, out_q;
	idx_t free_idx, disp_idx, ret_idx;
	logic disp_vld, disp_go, out_free, s2_ready, s1_ready;

	always_comb begin
		busy_o = 1'b1;
		free_idx = '0;
		disp_vld = 1'b0;
		disp_idx = '0;
		for (int i = core_pkg::MUL_RS - 1; i >= 0; i--) begin
			if (!rs_q[i].busy) begin
				busy_o = 1'b0;
				free_idx = idx_t'(i);
			end
			if (rs_q[i].busy && !rs_q[i].sent && rs_q[i].a.tag == '0 && rs_q[i].b.tag == '0) begin
				disp_vld = 1'b1;
				disp_idx = idx_t'(i);
			end
		end
	end

	assign free_tag_o = core_pkg::MUL_TAG_BASE + tag_t'(free_idx);
	assign ret_idx = idx_t'(out_q.tag - core_pkg::MUL_TAG_BASE);

	//--------------------------------------------------
	// Back-pressure, stages move only into empty slots
	//--------------------------------------------------
	assign out_free = ~out_q.valid | grant_i;
	assign s2_ready = ~s2_q.valid | out_free;
	assign s1_ready = ~s1_q.valid | s2_ready;
	assign disp_go = disp_vld & s1_ready;

	assign req_o = out_q.valid;
	assign result_o = out_q;

	always_ff @(posedge dbg_if) begin
		if (rst) begin
			s1_q.valid <= 1'b0;
			s2_q.valid <= 1'b0;
			out_q.valid <= 1'b0;
		end else begin
			if (out_free) out_q <= s2_q;
			if (s2_ready) begin
				s2_q.valid <= s1_q.valid;
				s2_q.tag <= s1_q.tag;
				s2_q.data <= s1_q.lo + {s1_q.mid, 16'h0000};
			end
			if (s1_ready) begin
				s1_q.valid <= disp_go;
				s1_q.tag <= core_pkg::MUL_TAG_BASE + tag_t'(disp_idx);
				s1_q.lo <= rs_q[disp_idx].a.val[15:0] * rs_q[disp_idx].b.val[15:0];
				s1_q.mid <= rs_q[disp_idx].a.val[15:0] * rs_q[disp_idx].b.val[31:16]
					+ rs_q[disp_idx].a.val[31:16] * rs_q[disp_idx].b.val[15:0];
			end
		end
	end

	// Station entries
	always_ff @(posedge dbg_if) begin
		if (rst) begin
			for (int i = 0; i < core_pkg::MUL_RS; i++) begin
				rs_q[i].busy <= 1'b0;
				rs_q[i].sent <= 1'b0;
			end
		end else begin
			for (int i = 0; i < core_pkg::MUL_RS; i++) begin
				if (issue_i.mul_issue && free_idx == idx_t'(i)) begin
					rs_q[i].busy <= 1'b1;
					rs_q[i].sent <= 1'b0;
					rs_q[i].a <= issue_i.op_a;
					rs_q[i].b <= issue_i.op_b;
				end else begin
					if (out_q.valid && grant_i && ret_idx == idx_t'(i)) begin
						rs_q[i].busy <= 1'b0;	// Tag reusable only after broadcast
					end
					if (disp_go && disp_idx == idx_t'(i)) rs_q[i].sent <= 1'b1;
					rs_q[i].a <= core_pkg::snoop(rs_q[i].a, cdb_i);
					rs_q[i].b <= core_pkg::snoop(rs_q[i].b, cdb_i);
				end
			end
		end
	end

	a_out_tag: assert property (@(posedge dbg_if) disable iff (rst)
		req_o |-> result_o.tag != '0);

endmodule

`default_nettype wire

/* source/tag_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module tag_regfile (
	input logic dbg_if,
	input logic rst,
	input logic [4:0] rs1_idx_i,
	input logic [4:0] rs2_idx_i,
	input core_pkg::issue_t issue_i,
	input core_pkg::cdb_t cdb_i,
	output core_pkg::tagged_t rs1_o,
	output core_pkg::tagged_t rs2_o,
	input logic [4:0] dbg_idx_i,
	output core_pkg::tagged_t dbg_reg_o
);

	core_pkg::tagged_t regs [32];	// Value plus pending producer tag

	//--------------------------------------------------
	// Rename and bus capture
	//--------------------------------------------------
	always_ff @(posedge dbg_if) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else begin
			// x0 is never written
			for (int i = 1; i < 32; i++) begin
				if (issue_i.rename_en && issue_i.rd == 5'(i)) begin
					regs[i].tag <= issue_i.tag;	// Newest producer wins over a same-edge broadcast
				end else begin
					regs[i] <= core_pkg::snoop(regs[i], cdb_i);
				end
			end
		end
	end

	// Reads see this cycle's broadcast
	assign rs1_o = core_pkg::snoop(regs[rs1_idx_i], cdb_i);
	assign rs2_o = core_pkg::snoop(regs[rs2_idx_i], cdb_i);

	assign dbg_reg_o = regs[dbg_idx_i];	// Raw state, no bypass

	// x0 must stay ready whatever issue does
	a_x0_ready: assert property (@(posedge dbg_if) disable iff (rst)
		regs[0].tag == '0);

endmodule

`default_nettype wire

/* source/tomasulo_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tomasulo_core (
	input logic dbg_if,
	input logic rst,
	input logic inst_valid_i,
	input isa_pkg::inst_u inst_i,
	output logic stall_o,
	input logic [6:0] debug_addr_i,
	output logic [core_pkg::DBG_W-1:0] debug_data_o
);

	logic [4:0] rs1_idx, rs2_idx;
	core_pkg::tagged_t rs1_op, rs2_op, dbg_reg;
	core_pkg::issue_t issue;
	logic alu_busy, mul_busy;
	logic [core_pkg::TAG_W-1:0] alu_free_tag, mul_free_tag;
	logic alu_req, mul_req, alu_grant, mul_grant;
	core_pkg::cdb_t alu_res, mul_res, cdb;	// cdb = the broadcast

	//--------------------------------------------------
	// Issue and rename
	//--------------------------------------------------
	issue_ctrl u_issue (
		.dbg_if(dbg_if), .rst(rst), .inst_valid_i(inst_valid_i), .inst_i(inst_i),
		.rs1_idx_o(rs1_idx), .rs2_idx_o(rs2_idx), .rs1_i(rs1_op), .rs2_i(rs2_op),
		.alu_busy_i(alu_busy), .mul_busy_i(mul_busy),
		.alu_free_tag_i(alu_free_tag), .mul_free_tag_i(mul_free_tag),
		.issue_o(issue), .stall_o(stall_o)
	);

	tag_regfile u_regs (
		.dbg_if(dbg_if), .rst(rst), .rs1_idx_i(rs1_idx), .rs2_idx_i(rs2_idx),
		.issue_i(issue), .cdb_i(cdb), .rs1_o(rs1_op), .rs2_o(rs2_op),
		.dbg_idx_i(debug_addr_i[4:0]), .dbg_reg_o(dbg_reg)	// Low five bits pick the register
	);

	//--------------------------------------------------
	// Functional units and result bus
	//--------------------------------------------------
	alu_station u_alu (
		.dbg_if(dbg_if), .rst(rst), .issue_i(issue), .cdb_i(cdb), .grant_i(alu_grant),
		.busy_o(alu_busy), .free_tag_o(alu_free_tag), .req_o(alu_req), .result_o(alu_res)
	);

	mul_station u_mul (
		.dbg_if(dbg_if), .rst(rst), .issue_i(issue), .cdb_i(cdb), .grant_i(mul_grant),
		.busy_o(mul_busy), .free_tag_o(mul_free_tag), .req_o(mul_req), .result_o(mul_res)
	);

	cdb_arbiter u_cdb (
		.alu_req_i(alu_req), .mul_req_i(mul_req), .alu_res_i(alu_res), .mul_res_i(mul_res),
		.alu_grant_o(alu_grant), .mul_grant_o(mul_grant), .cdb_o(cdb)
	);

	debug_mux u_dbg (
		.debug_addr_i(debug_addr_i), .dbg_reg_i(dbg_reg), .cdb_i(cdb),
		.alu_busy_i(alu_busy), .mul_busy_i(mul_busy), .stall_i(stall_o),
		.debug_data_o(debug_data_o)
	);

endmodule

`default_nettype wire

/* test/tb_tomasulo_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_tomasulo_core;

	localparam int CLK_HALF = 10;	// 20 ns period
	localparam int ACCEPT_LIMIT = 50;	// Cycles one word may stall
	localparam int DRAIN_LIMIT = 300;	// Cycles for all tags to clear

	// Local op codes for the table builder
	localparam int I_ADD = 0, I_SUB = 1, I_AND = 2, I_OR = 3, I_XOR = 4, I_SLL = 5;
	localparam int I_SRL = 6, I_MUL = 7, I_ADDI = 8, I_ANDI = 9, I_ORI = 10, I_XORI = 11;

	typedef struct packed {
		logic [31:0] word;
		logic last;	// Closes a test
	} step_t;

	logic dbg_if;
	logic rst;
	logic inst_valid_i;
	isa_pkg::inst_u inst_i;
	logic stall_o;
	logic [6:0] debug_addr_i;
	logic [core_pkg::DBG_W-1:0] debug_data_o;

	step_t tbl [$];
	string test_name [$];
	logic [31:0] model_regs [32];	// Architectural state in program order
	logic [31:0] rng_state;
	int errors;
	int checks;
	int tests_done;
	bit table_ready;

	tomasulo_core uut (
		.dbg_if(dbg_if), .rst(rst), .inst_valid_i(inst_valid_i), .inst_i(inst_i),
		.stall_o(stall_o), .debug_addr_i(debug_addr_i), .debug_data_o(debug_data_o)
	);

	always #CLK_HALF dbg_if = ~dbg_if;

	//--------------------------------------------------
	// Encoding, random source and model
	//--------------------------------------------------
	function automatic logic [31:0] make_op(int op, logic [4:0] rd, logic [4:0] rs1,
		logic [4:0] rs2, logic [11:0] imm);
		case (op)
			I_ADD: return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
			I_SUB: return {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
			I_AND: return {7'b0000000, rs2, rs1, 3'b111, rd, 7'b0110011};
			I_OR: return {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
			I_XOR: return {7'b0000000, rs2, rs1, 3'b100, rd, 7'b0110011};
			I_SLL: return {7'b0000000, rs2, rs1, 3'b001, rd, 7'b0110011};
			I_SRL: return {7'b0000000, rs2, rs1, 3'b101, rd, 7'b0110011};
			I_MUL: return {7'b0000001, rs2, rs1, 3'b000, rd, 7'b0110011};
			I_ADDI: return {imm, rs1, 3'b000, rd, 7'b0010011};
			I_ANDI: return {imm, rs1, 3'b111, rd, 7'b0010011};
			I_ORI: return {imm, rs1, 3'b110, rd, 7'b0010011};
			I_XORI: return {imm, rs1, 3'b100, rd, 7'b0010011};
			default: return 32'h0000_0003;	// Load opcode is not supported
		endcase
	endfunction

	function automatic logic [31:0] lcg_next();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return rng_state;
	endfunction

	task automatic model_exec(input logic [31:0] w);
		logic [31:0] a, b, imm, res;
		logic wr;
		a = model_regs[w[19:15]];
		b = model_regs[w[24:20]];
		imm = {{20{w[31]}}, w[31:20]};	// Sign-extended imm12
		wr = 1'b1;
		res = '0;
		if (w[6:0] == 7'b0110011 && w[31:25] == 7'b0000001 && w[14:12] == 3'b000) begin
			res = a * b;	// Low 32 bits
		end else if (w[6:0] == 7'b0110011 && w[31:25] == 7'b0100000 && w[14:12] == 3'b000) begin
			res = a - b;
		end else if (w[6:0] == 7'b0110011 && w[31:25] == 7'b0000000) begin
			case (w[14:12])
				3'b000: res = a + b;
				3'b001: res = a << b[4:0];
				3'b100: res = a ^ b;
				3'b101: res = a >> b[4:0];
				3'b110: res = a | b;
				3'b111: res = a & b;
				default: wr = 1'b0;
			endcase
		end else if (w[6:0] == 7'b0010011) begin
			case (w[14:12])
				3'b000: res = a + imm;
				3'b100: res = a ^ imm;
				3'b110: res = a | imm;
				3'b111: res = a & imm;
				default: wr = 1'b0;
			endcase
		end else begin
			wr = 1'b0;	// Dropped word
		end
		if (wr && w[11:7] != 5'd0) model_regs[w[11:7]] = res;
	endtask

	task automatic add_step(input logic [31:0] w, input logic last);
		step_t s;
		s.word = w;
		s.last = last;
		tbl.push_back(s);
	endtask

	task automatic build_table();
		logic [31:0] r1, r2;
		test_name.push_back("immediate forms");
		add_step(make_op(I_ADDI, 2, 0, 0, 12'hffb), 0);
		add_step(make_op(I_ORI, 3, 2, 0, 12'h0f0), 0);
		add_step(make_op(I_ANDI, 4, 3, 0, 12'h7ff), 0);
		add_step(make_op(I_XORI, 5, 4, 0, 12'hfff), 0);
		add_step(make_op(I_ADDI, 0, 5, 0, 12'd77), 0);	// x0 stays zero
		add_step(make_op(I_ADDI, 6, 1, 0, 12'h7ff), 0);
		add_step(make_op(I_XORI, 7, 6, 0, 12'h555), 0);
		add_step(make_op(I_ANDI, 8, 2, 0, 12'hff0), 1);
		test_name.push_back("register chains");
		add_step(make_op(I_ADD, 9, 1, 2, 0), 0);
		add_step(make_op(I_SUB, 10, 9, 6, 0), 0);
		add_step(make_op(I_AND, 11, 10, 3, 0), 0);
		add_step(make_op(I_OR, 12, 11, 7, 0), 0);
		add_step(make_op(I_XOR, 13, 12, 9, 0), 0);
		add_step(make_op(I_ADDI, 14, 0, 0, 12'd3), 0);
		add_step(make_op(I_SLL, 15, 13, 14, 0), 0);
		add_step(make_op(I_SRL, 16, 15, 14, 0), 0);
		add_step(make_op(I_SUB, 9, 16, 9, 0), 0);	// Rename over a live value
		add_step(make_op(I_ADD, 0, 9, 9, 0), 1);
		test_name.push_back("multiply mix");
		add_step(make_op(I_MUL, 17, 1, 2, 0), 0);
		add_step(make_op(I_MUL, 18, 17, 17, 0), 0);
		add_step(make_op(I_ADD, 19, 18, 1, 0), 0);
		add_step(make_op(I_MUL, 20, 18, 19, 0), 0);
		add_step(make_op(I_MUL, 21, 20, 6, 0), 0);
		add_step(make_op(I_ADDI, 22, 21, 0, 12'd1), 0);
		add_step(make_op(I_MUL, 17, 22, 17, 0), 0);
		add_step(make_op(I_XOR, 23, 17, 20, 0), 0);
		add_step(make_op(I_MUL, 24, 3, 7, 0), 0);
		add_step(make_op(I_MUL, 25, 24, 24, 0), 1);
		test_name.push_back("random mix");
		for (int k = 0; k < 24; k++) begin
			r1 = lcg_next();
			r2 = lcg_next();
			// Unknown opcodes with live sources and destinations outside the random range
			if (k == 8) add_step({12'h0ab, 5'd1, 3'b000, 5'd26, 7'b0000011}, 0);
			if (k == 16) add_step({7'b0000000, 5'd2, 5'd1, 3'b000, 5'd27, 7'b1111111}, 0);
			add_step(make_op(int'(r1[27:24]) % 12, {1'b0, r1[19:16]}, {1'b0, r1[23:20]},
				{1'b0, r1[15:12]}, r2[27:16]), k == 23);
		end
	endtask

	//--------------------------------------------------
	// Drive and observe
	//--------------------------------------------------
	task automatic apply_inst(input logic [31:0] word);
		int waited;
		logic taken;
		waited = 0;
		taken = 1'b0;
		if (!inst_valid_i) @(negedge dbg_if);	// New burst starts on a falling edge
		inst_valid_i = 1'b1;
		inst_i = word;
		while (!taken && waited < ACCEPT_LIMIT) begin
			#(CLK_HALF - 1);	// Just before the accepting edge
			taken = !stall_o;
			if (stall_o && word[6:0] != 7'b0110011 && word[6:0] != 7'b0010011) begin
				$display("Error at %0t ns: stall_o high for unknown opcode %h", $time, word);
				errors++;
			end
			@(negedge dbg_if);
			waited++;
		end
		if (!taken) begin
			$display("Instruction %h was never accepted, stall_o stayed high", word);
			errors++;
		end
	endtask

	task automatic read_dbg(input logic [6:0] addr, output logic [core_pkg::DBG_W-1:0] data);
		@(negedge dbg_if);
		debug_addr_i = addr;
		#(CLK_HALF / 2);	// Mid low phase where outputs have settled
		data = debug_data_o;
	endtask

	task automatic check_reg(input core_pkg::tagged_t got, input core_pkg::tagged_t exp,
		input string what);
		checks++;
		if (got !== exp) begin
			$display("Error at %0t ns: %s reads tag %0d value %h, expected tag %0d value %h",
				$time, what, got.tag, got.val, exp.tag, exp.val);
			errors++;
		end
	endtask

	task automatic check_cdb(input core_pkg::cdb_t got, input core_pkg::cdb_t exp, input string what);
		checks++;
		if (got !== exp) begin
			$display("Error at %0t ns: %s shows valid %b tag %0d data %h, expected %b %0d %h",
				$time, what, got.valid, got.tag, got.data, exp.valid, exp.tag, exp.data);
			errors++;
		end
	endtask

	task automatic check_dbg(input logic [core_pkg::DBG_W-1:0] got,
		input logic [core_pkg::DBG_W-1:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			$display("Error at %0t ns: %s reads %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	// Poll every register until its producer has broadcast
	task automatic drain();
		logic [core_pkg::DBG_W-1:0] d;
		core_pkg::tagged_t r;
		int waited;
		waited = 0;
		for (int i = 1; i < 32; i++) begin
			read_dbg(7'(i), d);
			r = d[$bits(core_pkg::tagged_t)-1:0];
			while (r.tag != '0 && waited < DRAIN_LIMIT) begin
				read_dbg(7'(i), d);
				r = d[$bits(core_pkg::tagged_t)-1:0];
				waited++;
			end
			if (r.tag != '0) begin
				$display("Drain timed out, x%0d still waits on tag %0d", i, r.tag);
				errors++;
				return;
			end
		end
	endtask

	task automatic check_state();
		logic [core_pkg::DBG_W-1:0] d;
		core_pkg::tagged_t exp;
		core_pkg::cdb_t bus;
		for (int i = 0; i < 32; i++) begin
			read_dbg(7'(i), d);
			exp.tag = '0;
			exp.val = model_regs[i];
			check_reg(d[$bits(core_pkg::tagged_t)-1:0], exp, $sformatf("x%0d", i));
		end
		read_dbg(7'd32, d);
		bus = d[$bits(core_pkg::cdb_t)-1:0];
		checks++;
		if (bus.valid !== 1'b0) begin
			$display("Error at %0t ns: bus valid high with nothing in flight", $time);
			errors++;
		end
		read_dbg(7'd33, d);
		check_dbg(d, '0, "busy and stall view");	// Idle core with no valid word
	endtask

	task automatic report_test(input string name, input int fails);
		tests_done++;
		$display("Test %s: %s, %0d errors", name, (fails == 0) ? "ok" : "failed", fails);
	endtask

	// stall_o may only answer a presented word
	always @(posedge dbg_if) begin
		if (!rst && !inst_valid_i && stall_o) begin
			$display("Error at %0t ns: stall_o high while inst_valid_i is low", $time);
			errors++;
		end
	end

	initial begin
		wait (table_ready);
		repeat ((tbl.size() + 10) * 40) @(posedge dbg_if);
		$display("Watchdog expired after %0d cycles, the run did not finish",
			(tbl.size() + 10) * 40);
		$display("Simulation finished: FAIL");
		$finish;
	end

	//--------------------------------------------------
	// Main sequence
	//--------------------------------------------------
	initial begin
		logic [core_pkg::DBG_W-1:0] d;
		core_pkg::cdb_t bus, exp_bus;
		int mark;
		int t;
		int waited;
		dbg_if = 1'b0;
		rst = 1'b1;
		inst_valid_i = 1'b0;
		inst_i = '0;
		debug_addr_i = '0;
		errors = 0;
		checks = 0;
		tests_done = 0;
		rng_state = 32'h96cd;
		for (int i = 0; i < 32; i++) model_regs[i] = '0;
		build_table();
		table_ready = 1'b1;
		repeat (5) @(posedge dbg_if);
		@(negedge dbg_if);
		rst = 1'b0;

		// Reset state and unmapped addresses
		mark = errors;
		check_state();
		read_dbg(7'd34, d);
		check_dbg(d, core_pkg::DBG_DEFAULT, "unmapped address 34");
		read_dbg(7'd127, d);
		check_dbg(d, core_pkg::DBG_DEFAULT, "unmapped address 127");
		report_test("reset state", errors - mark);

		// One ready ADDI that the lowest ALU station broadcasts
		mark = errors;
		@(negedge dbg_if);
		debug_addr_i = 7'd32;
		apply_inst(make_op(I_ADDI, 1, 0, 0, 12'd123));
		inst_valid_i = 1'b0;
		model_exec(make_op(I_ADDI, 1, 0, 0, 12'd123));
		waited = 0;
		#(CLK_HALF / 2);
		bus = debug_data_o[$bits(core_pkg::cdb_t)-1:0];
		while (!bus.valid && waited < DRAIN_LIMIT) begin
			@(negedge dbg_if);
			#(CLK_HALF / 2);
			bus = debug_data_o[$bits(core_pkg::cdb_t)-1:0];
			waited++;
		end
		exp_bus.valid = 1'b1;
		exp_bus.tag = core_pkg::ALU_TAG_BASE;
		exp_bus.data = 32'd123;
		check_cdb(bus, exp_bus, "first broadcast");
		drain();
		report_test("first broadcast", errors - mark);

		t = 0;
		mark = errors;
		for (int n = 0; n < tbl.size(); n++) begin
			apply_inst(tbl[n].word);
			model_exec(tbl[n].word);
			if (tbl[n].last) begin
				inst_valid_i = 1'b0;
				drain();
				check_state();
				report_test(test_name[t], errors - mark);
				t++;
				mark = errors;
			end
		end

		$display("%0d tests, %0d checks, %0d errors", tests_done, checks, errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
